// File: hw/tenBaseTPkg.sv
`default_nettype none

package tenBaseTPkg;

	//////////////////////////////////////////////////////////////////////
	// Data and buffer types

	// One line byte
	typedef logic [7:0] byteT;

	// Frame buffer size in bytes
	localparam int bufDepth = 512;

	// Address into the frame buffer
	typedef logic [$clog2(bufDepth)-1:0] bufAddrT;

	//////////////////////////////////////////////////////////////////////
	// Ethernet framing constants

	// Bytes ahead of the payload, seven preamble plus the SFD
	localparam int preambleLen = 8;
	localparam byteT preambleByte = 8'h55;
	localparam byteT sfdByte = 8'hD5;

	// CRC-32 as used for the Ethernet FCS
	localparam logic [31:0] crcPoly = 32'h04C11DB7;

	// Value a CRC over payload plus FCS settles on
	localparam logic [31:0] crcResidue = 32'hC704DD7B;

	// FCS bytes after the payload
	localparam int fcsLen = 4;

	//////////////////////////////////////////////////////////////////////
	// Line timing

	// Clocks of TP_IDL high level after the last bit
	localparam int idleTailCycles = 6;

	// Link pulse timer width, one pulse per 2**17 clocks
	localparam int linkPulseBits = 17;

endpackage

`default_nettype wire

// File: hw/frameBufIf.sv
`timescale 1ns/1ps
`default_nettype none

interface frameBufIf;
	import tenBaseTPkg::*;

	// Frame launch, one clock wide
	logic start;
	// Address of the last payload byte
	bufAddrT payloadLen;
	// Buffer byte at rdAddr, one clock late
	byteT rdData;
	// Read address from the sequencer
	bufAddrT rdAddr;
	// Frame on the line, locks the buffer
	logic sending;

	// Buffer side
	modport loader (
		output start,
		output payloadLen,
		output rdData,
		input rdAddr,
		input sending
	);

	// Sequencer side
	modport sequencer (
		input start,
		input payloadLen,
		input rdData,
		output rdAddr,
		output sending
	);

endinterface

`default_nettype wire

// File: hw/fcsIf.sv
`timescale 1ns/1ps
`default_nettype none

interface fcsIf;

	// One strobe per transmitted bit
	logic shiftEn;
	// Bit going into the CRC
	logic dataBit;
	// Preset to all ones
	logic init;
	// FCS bytes on the line, CRC shifts out
	logic flush;
	// Next FCS bit, already inverted
	logic fcsBit;

	modport sequencer (
		output shiftEn,
		output dataBit,
		output init,
		output flush,
		input fcsBit
	);

	modport generator (
		input shiftEn,
		input dataBit,
		input init,
		input flush,
		output fcsBit
	);

endinterface

`default_nettype wire

// File: hw/frameLoader.sv
`timescale 1ns/1ps
`default_nettype none

module frameLoader (
	input wire logic clkTx,
	input wire logic rstN,
	input wire logic wrEn,
	input wire tenBaseTPkg::byteT wrData,
	input wire logic frameEnd,
	frameBufIf.loader frameBuf
);
	import tenBaseTPkg::*;

	// Payload store
	byteT ram [bufDepth];

	// Next free address
	bufAddrT wrPtr;
	// At least one byte since the last launch
	logic hasData;
	// Buffer belongs to the sequencer
	logic locked;
	// Byte actually stored this clock
	logic wrAccept;
	// Frame handed over this clock
	logic launch;

	// Busy from the launch clock to the end of the frame
	assign locked = frameBuf.sending | frameBuf.start;
	assign wrAccept = wrEn & ~locked;

	// A byte arriving together with frameEnd still belongs to the frame
	assign launch = frameEnd & ~locked & (hasData | wrEn);

	//////////////////////////////////////////////////////////////////////
	// Buffer RAM, one write port and one registered read port

	always_ff @(posedge clkTx)
	begin
		if (wrAccept)
		begin
			ram[wrPtr] <= wrData;
		end
		frameBuf.rdData <= ram[frameBuf.rdAddr];
	end

	//////////////////////////////////////////////////////////////////////
	// Write pointer and launch

	always_ff @(posedge clkTx)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			hasData <= 1'b0;
			frameBuf.start <= 1'b0;
		end
		else
		begin
			frameBuf.start <= launch;
			if (launch)
			begin
				// Next payload starts at address zero
				wrPtr <= '0;
				hasData <= 1'b0;
			end
			else if (wrAccept)
			begin
				wrPtr <= wrPtr + 1'b1;
				hasData <= 1'b1;
			end
		end
	end

	// Last payload address, includes a byte written in the launch clock
	always_ff @(posedge clkTx)
	begin
		if (launch)
		begin
			frameBuf.payloadLen <= wrAccept ? wrPtr : wrPtr - 1'b1;
		end
	end

	// The sequencer has dropped sending before another launch
	startIdle: assert property (@(posedge clkTx) disable iff (!rstN)
		frameBuf.start |-> !frameBuf.sending);

	// Full buffer, a further byte would overwrite the first one
	noWrap: assert property (@(posedge clkTx) disable iff (!rstN)
		wrAccept && hasData |-> wrPtr != '0);

endmodule

`default_nettype wire

// File: hw/frameSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frameSequencer (
	input wire logic clkTx,
	input wire logic rstN,
	frameBufIf.sequencer frameBuf,
	fcsIf.sequencer fcs,
	output logic sending,
	output logic lineBit,
	output logic bitHalf,
	output logic busy
);
	import tenBaseTPkg::*;

	// Byte index over preamble, SFD, payload and FCS
	typedef logic [$clog2(preambleLen + bufDepth + fcsLen)-1:0] frameAddrT;

	frameAddrT frameAddr;
	frameAddrT nextAddr;
	// Frame address of the last payload byte
	frameAddrT payEnd;
	// Frame address of the last FCS byte
	frameAddrT lastAddr;
	// Bit within the current byte
	logic [2:0] bitCnt;
	// Byte going out, LSB first
	byteT shiftReg;
	byteT nextByte;
	logic byteEnd;

	assign nextAddr = frameAddr + 1'b1;
	assign payEnd = frameAddrT'(frameBuf.payloadLen) + frameAddrT'(preambleLen);
	assign lastAddr = payEnd + frameAddrT'(fcsLen);

	// Second half of the eighth bit
	assign byteEnd = bitHalf && (bitCnt == 3'd7);

	// Read one byte ahead, the RAM has a full byte time to answer
	assign frameBuf.rdAddr = bufAddrT'(nextAddr - frameAddrT'(preambleLen));
	assign frameBuf.sending = sending;

	// Busy covers the launch clock too
	assign busy = sending | frameBuf.start;

	//////////////////////////////////////////////////////////////////////
	// Byte source

	always_comb
	begin
		if (nextAddr < frameAddrT'(preambleLen - 1))
			nextByte = preambleByte;
		else if (nextAddr == frameAddrT'(preambleLen - 1))
			nextByte = sfdByte;
		else
			// Payload, and don't care during the FCS
			nextByte = frameBuf.rdData;
	end

	//////////////////////////////////////////////////////////////////////
	// Bit and byte counters

	always_ff @(posedge clkTx)
	begin
		if (!rstN)
		begin
			sending <= 1'b0;
			bitHalf <= 1'b0;
			bitCnt <= '0;
			frameAddr <= '0;
		end
		else if (!sending)
		begin
			bitHalf <= 1'b0;
			bitCnt <= '0;
			frameAddr <= '0;
			if (frameBuf.start)
				sending <= 1'b1;
		end
		else
		begin
			// Two clocks per bit, no stall
			bitHalf <= ~bitHalf;
			if (bitHalf)
				bitCnt <= bitCnt + 1'b1;
			if (byteEnd)
			begin
				frameAddr <= nextAddr;
				if (frameAddr == lastAddr)
					sending <= 1'b0;
			end
		end
	end

	// Shift register, first preamble byte preloaded while idle
	always_ff @(posedge clkTx)
	begin
		if (!sending)
			shiftReg <= preambleByte;
		else if (byteEnd)
			shiftReg <= nextByte;
		else if (bitHalf)
			shiftReg <= {1'b0, shiftReg[7:1]};
	end

	//////////////////////////////////////////////////////////////////////
	// CRC control and line bit

	// CRC preset during preamble and SFD, covers payload only
	assign fcs.init = sending && (frameAddr < frameAddrT'(preambleLen));
	assign fcs.flush = sending && (frameAddr > payEnd);
	assign fcs.shiftEn = sending && bitHalf;
	assign fcs.dataBit = shiftReg[0];

	assign lineBit = fcs.flush ? fcs.fcsBit : shiftReg[0];

	// Both halves of a bit carry the same value, the CRC included
	bitStable: assert property (@(posedge clkTx) disable iff (!rstN)
		sending && !bitHalf |=> $stable(lineBit));

endmodule

`default_nettype wire

// File: hw/fcsGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module fcsGenerator (
	input wire logic clkTx,
	input wire logic rstN,
	fcsIf.generator fcs
);
	import tenBaseTPkg::*;

	// CRC state, MSB is the next bit out
	logic [31:0] crc;
	// Serial feedback tap
	logic feedback;

	assign feedback = fcs.dataBit ^ crc[31];

	//////////////////////////////////////////////////////////////////////
	// Serial CRC-32, one step per line bit

	always_ff @(posedge clkTx)
	begin
		if (!rstN)
		begin
			crc <= '1;
		end
		else if (fcs.shiftEn)
		begin
			if (fcs.init)
				crc <= '1;
			else if (fcs.flush)
				// Plain shift, the remainder leaves MSB first
				crc <= {crc[30:0], 1'b0};
			else
				crc <= {crc[30:0], 1'b0} ^ (crcPoly & {32{feedback}});
		end
	end

	// FCS is the ones complement of the remainder
	assign fcs.fcsBit = ~crc[31];

endmodule

`default_nettype wire

// File: hw/lineEncoder.sv
`timescale 1ns/1ps
`default_nettype none

module lineEncoder (
	input wire logic clkTx,
	input wire logic rstN,
	input wire logic sending,
	input wire logic lineBit,
	input wire logic bitHalf,
	output logic tdP,
	output logic tdM
);
	import tenBaseTPkg::*;

	typedef logic [$clog2(idleTailCycles + 1)-1:0] tailCntT;

	// Idle time since the last frame
	logic [linkPulseBits-1:0] linkTimer;
	// Clocks of TP_IDL already sent
	tailCntT tailCnt;
	logic tailActive;
	logic linkPulse;
	// Manchester level for this half bit
	logic manchester;

	// First half inverted, second half true
	assign manchester = bitHalf ? lineBit : ~lineBit;

	assign tailActive = tailCnt < tailCntT'(idleTailCycles);

	// Last two counts of the period
	assign linkPulse = &linkTimer[linkPulseBits-1:1];

	//////////////////////////////////////////////////////////////////////
	// Line drive, one register stage

	always_ff @(posedge clkTx)
	begin
		if (!rstN)
		begin
			linkTimer <= '0;
			// No tail after reset
			tailCnt <= tailCntT'(idleTailCycles);
			tdP <= 1'b0;
			tdM <= 1'b0;
		end
		else
		begin
			// Frames restart the idle period
			if (sending)
				linkTimer <= '0;
			else
				linkTimer <= linkTimer + 1'b1;

			if (sending)
				tailCnt <= '0;
			else if (tailActive)
				tailCnt <= tailCnt + 1'b1;

			if (sending)
			begin
				tdP <= manchester;
				tdM <= ~manchester;
			end
			else if (tailActive || linkPulse)
			begin
				// TP_IDL and NLP are a positive level only
				tdP <= 1'b1;
				tdM <= 1'b0;
			end
			else
			begin
				tdP <= 1'b0;
				tdM <= 1'b0;
			end
		end
	end

	// Differential pair never shorted high
	pairExclusive: assert property (@(posedge clkTx) disable iff (!rstN)
		!(tdP && tdM));

endmodule

`default_nettype wire

// File: hw/tenBaseTTx.sv
`timescale 1ns/1ps
`default_nettype none

module tenBaseTTx (
	input wire logic clkTx,
	input wire logic rstN,
	input wire logic wrEn,
	input wire tenBaseTPkg::byteT wrData,
	input wire logic frameEnd,
	output logic busy,
	output logic tdP,
	output logic tdM
);

	// Buffer handshake and CRC control
	frameBufIf frameBuf();
	fcsIf fcs();

	// Sequencer to encoder
	logic sending;
	logic lineBit;
	logic bitHalf;

	//////////////////////////////////////////////////////////////////////
	// Input side

	frameLoader loader (
		.clkTx(clkTx),
		.rstN(rstN),
		.wrEn(wrEn),
		.wrData(wrData),
		.frameEnd(frameEnd),
		.frameBuf(frameBuf.loader)
	);

	//////////////////////////////////////////////////////////////////////
	// Bit stream and FCS

	frameSequencer sequencer (
		.clkTx(clkTx),
		.rstN(rstN),
		.frameBuf(frameBuf.sequencer),
		.fcs(fcs.sequencer),
		.sending(sending),
		.lineBit(lineBit),
		.bitHalf(bitHalf),
		.busy(busy)
	);

	fcsGenerator fcsGen (
		.clkTx(clkTx),
		.rstN(rstN),
		.fcs(fcs.generator)
	);

	// Line pair
	lineEncoder encoder (
		.clkTx(clkTx),
		.rstN(rstN),
		.sending(sending),
		.lineBit(lineBit),
		.bitHalf(bitHalf),
		.tdP(tdP),
		.tdM(tdM)
	);

endmodule

`default_nettype wire

// File: testbench/tbLineMonitor.sv
`timescale 1ns/1ps
`default_nettype none

module tbLineMonitor (
	input wire logic clkTx,
	input wire logic tdP,
	input wire logic tdM
);
	import tenBaseTPkg::*;

	// Decoder states
	localparam int stIdle = 0;
	localparam int stFirst = 1;
	localparam int stSecond = 2;
	localparam int stTail = 3;

	int state = stIdle;
	int cycle = 0;
	// tdP seen in the first half of the running bit
	logic firstP;
	byteT shiftByte;
	int bitCnt;
	int byteCount;
	// Serial CRC over the bits after the SFD
	logic [31:0] crc;
	int tailCount;
	// Link pulse tracking
	int pulseLen = 0;
	int pulseStart;
	int prevStart;
	logic havePrev = 1'b0;

	// Results for the testbench, strobes last one clock
	logic halfErr = 1'b0;
	logic byteStrobe = 1'b0;
	byteT byteData;
	int byteIdx;
	logic frameDone = 1'b0;
	int frameBytes;
	int bitsLeft;
	logic [31:0] residue;
	int framesSeen = 0;
	logic tailDone = 1'b0;
	int tailLen;
	logic tailEndLow;
	int tailsSeen = 0;
	logic pulseDone = 1'b0;
	int pulseWidth;
	int pulseGap;
	logic gapValid;
	int pulseCount = 0;

	// Hand the finished frame over, then count the TP_IDL level
	task automatic closeFrame(input int tailSoFar);
		frameDone = 1'b1;
		frameBytes = byteCount;
		bitsLeft = bitCnt;
		residue = crc;
		framesSeen++;
		tailCount = tailSoFar;
		state = stTail;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sampling at the falling edge, the line moves on the rising one

	always @(negedge clkTx)
	begin
		halfErr = 1'b0;
		byteStrobe = 1'b0;
		frameDone = 1'b0;
		tailDone = 1'b0;
		pulseDone = 1'b0;
		cycle++;
		if (state == stIdle)
		begin
			if (tdM)
			begin
				// First preamble bit is a one, so its first half drives tdM
				firstP = tdP;
				bitCnt = 0;
				byteCount = 0;
				crc = '1;
				havePrev = 1'b0;
				pulseLen = 0;
				state = stSecond;
			end
			else if (tdP)
			begin
				if (pulseLen == 0)
					pulseStart = cycle;
				pulseLen++;
			end
			else if (pulseLen != 0)
			begin
				pulseDone = 1'b1;
				pulseWidth = pulseLen;
				pulseGap = pulseStart - prevStart;
				gapValid = havePrev;
				prevStart = pulseStart;
				havePrev = 1'b1;
				pulseCount++;
				pulseLen = 0;
			end
		end
		else if (state == stFirst)
		begin
			// A half bit always has tdM opposite tdP
			if (tdM == tdP)
				closeFrame(0);
			else
			begin
				firstP = tdP;
				state = stSecond;
			end
		end
		else if (state == stSecond)
		begin
			if (tdP != firstP && tdM != tdP)
			begin
				// Second half carries the bit, bytes arrive LSB first
				shiftByte = {tdP, shiftByte[7:1]};
				if (byteCount >= preambleLen)
					crc = {crc[30:0], 1'b0} ^ (crcPoly & {32{tdP ^ crc[31]}});
				bitCnt++;
				if (bitCnt == 8)
				begin
					byteStrobe = 1'b1;
					byteData = shiftByte;
					byteIdx = byteCount;
					byteCount++;
					bitCnt = 0;
				end
				state = stFirst;
			end
			else if (firstP && tdP && !tdM)
				// Two high clocks, the previous sample already was TP_IDL
				closeFrame(1);
			else
			begin
				halfErr = 1'b1;
				state = stFirst;
			end
		end
		if (state == stTail)
		begin
			if (tdP && !tdM)
				tailCount++;
			else
			begin
				tailDone = 1'b1;
				tailLen = tailCount;
				tailEndLow = !tdP && !tdM;
				tailsSeen++;
				state = stIdle;
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tenBaseTTxTb.sv
`timescale 1ns/1ps
`default_nettype none

module tenBaseTTxTb;
	import tenBaseTPkg::*;

	localparam int numFrames = 5;
	localparam int linkPeriod = 2 ** linkPulseBits;

	logic clkTx;
	logic rstN;
	logic wrEn;
	byteT wrData;
	logic frameEnd;
	logic busy;
	logic tdP;
	logic tdM;

	// Payload of the frame now on the line
	byteT expPay [bufDepth];
	int expLen;
	int lengths [numFrames];
	logic [31:0] lfsrState;
	int cycleCount = 0;
	int cycleLimit;

	tenBaseTTx u_dut (
		.clkTx(clkTx),
		.rstN(rstN),
		.wrEn(wrEn),
		.wrData(wrData),
		.frameEnd(frameEnd),
		.busy(busy),
		.tdP(tdP),
		.tdM(tdM)
	);

	tbLineMonitor lineMon (
		.clkTx(clkTx),
		.tdP(tdP),
		.tdM(tdM)
	);

	initial
	begin
		clkTx = 1'b0;
		forever #2 clkTx = ~clkTx;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		abortRun($sformatf("mismatch %s: got %h expected %h", name, got, expected));
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int takeBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			v = (v << 1) | int'(lfsrState[0]);
		end
		return v;
	endfunction

	// Byte expected at a frame position, -1 inside the FCS
	function automatic int expectedByte(input int idx);
		if (idx < preambleLen - 1)
			return int'(preambleByte);
		if (idx == preambleLen - 1)
			return int'(sfdByte);
		if (idx < preambleLen + expLen)
			return int'(expPay[idx - preambleLen]);
		return -1;
	endfunction

	task automatic nextCycle;
		@(posedge clkTx);
		#1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checks on the line and on the decoded stream

	// Line pair sampled away from the rising edge
	always @(negedge clkTx)
	begin
		if (rstN)
		begin
			assert (!(tdP && tdM)) else abortRun("tdP and tdM are both high");
		end
	end

	always @(posedge clkTx)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit)
			abortRun("timeout, the line traffic did not complete in time");
		assert (!lineMon.halfErr) else abortRun("bit halves on tdP/tdM are not complementary");
		if (lineMon.byteStrobe && expectedByte(lineMon.byteIdx) >= 0)
		begin
			assert (int'(lineMon.byteData) == expectedByte(lineMon.byteIdx))
			else reportMismatch($sformatf("byteData[%0d]", lineMon.byteIdx),
				32'(lineMon.byteData), expectedByte(lineMon.byteIdx));
		end
		if (lineMon.frameDone)
		begin
			assert (lineMon.frameBytes == preambleLen + expLen + fcsLen)
			else reportMismatch("frameBytes", lineMon.frameBytes,
				preambleLen + expLen + fcsLen);
			assert (lineMon.bitsLeft == 0)
			else reportMismatch("bitsLeft", lineMon.bitsLeft, 0);
			assert (lineMon.residue == crcResidue)
			else reportMismatch("residue", lineMon.residue, crcResidue);
		end
		if (lineMon.tailDone)
		begin
			assert (lineMon.tailLen == idleTailCycles)
			else reportMismatch("tailLen", lineMon.tailLen, idleTailCycles);
			assert (lineMon.tailEndLow) else abortRun("line not low after the TP_IDL tail");
		end
		if (lineMon.pulseDone)
		begin
			assert (lineMon.pulseWidth == 2)
			else reportMismatch("pulseWidth", lineMon.pulseWidth, 2);
			if (lineMon.gapValid)
			begin
				assert (lineMon.pulseGap == linkPeriod)
				else reportMismatch("pulseGap", lineMon.pulseGap, linkPeriod);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	initial
	begin
		rstN = 1'b0;
		wrEn = 1'b0;
		wrData = '0;
		frameEnd = 1'b0;
		expLen = 0;
		lfsrState = 32'h35e5;
		// Shortest and longest payload first, then random lengths
		lengths[0] = 1;
		lengths[1] = bufDepth;
		for (int f = 2; f < numFrames; f++)
			lengths[f] = 1 + takeBits(9);
		cycleLimit = 16 + 2 * linkPeriod + 500;
		for (int f = 0; f < numFrames; f++)
			cycleLimit += 16 * (lengths[f] + preambleLen + fcsLen) + lengths[f] + 20;

		repeat (16) @(posedge clkTx);
		#1;
		rstN = 1'b1;

		for (int f = 0; f < numFrames; f++)
		begin
			expLen = lengths[f];
			for (int i = 0; i < expLen; i++)
			begin
				expPay[i] = byteT'(takeBits(8));
				nextCycle();
				wrEn = 1'b1;
				wrData = expPay[i];
			end
			nextCycle();
			wrEn = 1'b0;
			frameEnd = 1'b1;
			nextCycle();
			frameEnd = 1'b0;
			while (!busy)
				nextCycle();
			// Write and frameEnd while busy, both dropped
			nextCycle();
			wrEn = 1'b1;
			wrData = byteT'(takeBits(8));
			frameEnd = 1'b1;
			nextCycle();
			wrEn = 1'b0;
			frameEnd = 1'b0;
			while (lineMon.tailsSeen < f + 1)
				nextCycle();
			assert (!busy) else abortRun("a frameEnd during busy launched an extra frame");
		end

		// Idle line, two link pulses give one spacing
		while (lineMon.pulseCount < 2)
			nextCycle();
		if (lineMon.framesSeen == numFrames)
		begin
			$display("test passed");
			$finish;
		end
		else
			reportMismatch("framesSeen", lineMon.framesSeen, numFrames);
	end

endmodule

`default_nettype wire

// File: flist.f
hw/tenBaseTPkg.sv
hw/frameBufIf.sv
hw/fcsIf.sv
hw/frameLoader.sv
hw/frameSequencer.sv
hw/fcsGenerator.sv
hw/lineEncoder.sv
hw/tenBaseTTx.sv
testbench/tbLineMonitor.sv
testbench/tenBaseTTxTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run, the exit status is the simulation result
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f flist.f --top-module tenBaseTTxTb \
		-Mdir obj_dir -o simTenBaseTTx \
	&& ./obj_dir/simTenBaseTTx \
	|| exit 1
